//--- Bender.yml
package:
  name: soc_mem

sources:
  - files:
      - rtl/soc_pkg.sv
      - rtl/mem_fabric.sv
      - rtl/bram.sv
      - rtl/uart_periph.sv
      - rtl/timer_periph.sv
      - rtl/soc_top.sv
  - target: test
    files:
      - verification/tb_soc.sv

//--- rtl/bram.sv
`timescale 1ns/1ps
`default_nettype none

module bram (
  input  logic              clk_pll,
  input  soc_pkg::mem_req_t req,
  output logic [31:0]       rdata
);
  import soc_pkg::*;

  logic [31:0]               mem [BRAM_DEPTH_WORDS];
  logic [BRAM_ADDR_BITS-1:0] word_idx;
  logic                      wen;

  // upper address bits are ignored, so the array aliases every 4 KB.
  assign word_idx = req.addr[BRAM_ADDR_BITS+1:2];
  assign wen      = req.valid & (|req.wstrb);

  always_ff @(posedge clk_pll) begin
    if (wen) begin
      for (int b = 0; b < 4; b++) begin
        if (req.wstrb[b]) begin
          mem[word_idx][8*b +: 8] <= req.wdata[8*b +: 8];
        end
      end
    end
    rdata <= mem[word_idx];                  // read-first on a write.
  end

  // a held request must not change its address before ready.
  a_addr_stable: assert property (@(posedge clk_pll)
    req.valid && $past(req.valid) |-> $stable(req.addr))
    else $error("bram: address changed while valid was held");

endmodule

`default_nettype wire

//--- rtl/mem_fabric.sv
`timescale 1ns/1ps
`default_nettype none

module mem_fabric (
  input  logic              clk_pll,
  input  logic              rst_n,
  input  soc_pkg::mem_req_t bus_req,
  output soc_pkg::mem_rsp_t bus_rsp,
  output soc_pkg::mem_req_t bram_req,
  input  logic [31:0]       bram_rdata,
  output soc_pkg::mem_req_t uart_req,
  output soc_pkg::mem_req_t timer_req,
  input  soc_pkg::mem_rsp_t uart_rsp,
  input  soc_pkg::mem_rsp_t timer_rsp
);
  import soc_pkg::*;

  logic uart_hit;
  logic timer_hit;
  logic bram_ready;

  // ==========================================================================
  // address decode
  // ==========================================================================

  assign uart_hit  = (bus_req.addr >= UART_BASE_ADDR) && (bus_req.addr < UART_TOP_ADDR);
  assign timer_hit = (bus_req.addr >= TIMER_BASE_ADDR) && (bus_req.addr < TIMER_TOP_ADDR);

  always_comb begin
    bram_req       = bus_req;
    bram_req.valid = bus_req.valid & ~uart_hit & ~timer_hit;  // fall-through target.

    uart_req       = bus_req;
    uart_req.valid = bus_req.valid & uart_hit;
    uart_req.addr  = bus_req.addr ^ UART_BASE_ADDR;           // local offset.

    timer_req       = bus_req;
    timer_req.valid = bus_req.valid & timer_hit;
    timer_req.addr  = bus_req.addr ^ TIMER_BASE_ADDR;
  end

  // ==========================================================================
  // ram ready and response select
  // ==========================================================================

  // one ready pulse per request even while valid is still held.
  always_ff @(posedge clk_pll or negedge rst_n) begin
    if (!rst_n) begin
      bram_ready <= 1'b0;
    end else begin
      bram_ready <= bram_req.valid & ~bram_ready;
    end
  end

  always_comb begin
    if (bram_ready) begin
      bus_rsp.ready = 1'b1;
      bus_rsp.rdata = bram_rdata;
    end else if (uart_rsp.ready) begin
      bus_rsp = uart_rsp;
    end else if (timer_rsp.ready) begin
      bus_rsp = timer_rsp;
    end else begin
      bus_rsp = '0;                                           // idle bus.
    end
  end

  // only one target may be addressed or answering in any cycle.
  a_one_target: assert property (@(posedge clk_pll) disable iff (!rst_n)
    $onehot0({bram_req.valid, uart_req.valid, timer_req.valid}) &&
    $onehot0({bram_ready, uart_rsp.ready, timer_rsp.ready}))
    else $error("mem_fabric: more than one target valid or ready");

endmodule

`default_nettype wire

//--- rtl/soc_pkg.sv
`default_nettype none

package soc_pkg;

  // ==========================================================================
  // address map
  // ==========================================================================

  localparam logic [31:0] UART_BASE_ADDR  = 32'h1000_0000;
  localparam logic [31:0] UART_TOP_ADDR   = 32'h1000_0010;
  localparam logic [31:0] TIMER_BASE_ADDR = 32'h2000_0000;
  localparam logic [31:0] TIMER_TOP_ADDR  = 32'h2000_0010;

  // ram takes every address outside the two peripheral windows.
  localparam int BRAM_DEPTH_WORDS = 1024;
  localparam int BRAM_ADDR_BITS   = 10;   // word index from addr[11:2].

  // ==========================================================================
  // peripherals
  // ==========================================================================

  localparam int UART_CLKS_PER_BIT = 8;
  localparam int UART_CNT_BITS     = $clog2(UART_CLKS_PER_BIT);
  localparam int UART_FRAME_BITS   = 10;  // start, 8 data, stop.

  localparam logic [3:0] UART_REG_DATA   = 4'h0;
  localparam logic [3:0] UART_REG_STATUS = 4'h4;

  localparam logic [3:0] TIMER_REG_TIME_LO = 4'h0;
  localparam logic [3:0] TIMER_REG_TIME_HI = 4'h4;
  localparam logic [3:0] TIMER_REG_CMP_LO  = 4'h8;
  localparam logic [3:0] TIMER_REG_CMP_HI  = 4'hc;

  // ==========================================================================
  // bus
  // ==========================================================================

  typedef struct packed {
    logic        valid;
    logic        instr;   // instruction fetch.
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;   // all zero for a read.
  } mem_req_t;

  typedef struct packed {
    logic        ready;
    logic [31:0] rdata;
  } mem_rsp_t;

endpackage

`default_nettype wire

//--- rtl/soc_top.sv
`timescale 1ns/1ps
`default_nettype none

module soc_top (
  input  logic              clk_pll,
  input  logic              rst_n,
  input  logic              rtc,
  input  soc_pkg::mem_req_t bus_req,
  output soc_pkg::mem_rsp_t bus_rsp,
  input  logic              rx,
  output logic              tx,
  output logic              timer_irq
);
  import soc_pkg::*;

  mem_req_t    bram_req;
  mem_req_t    uart_req;
  mem_req_t    timer_req;
  logic [31:0] bram_rdata;
  mem_rsp_t    uart_rsp;
  mem_rsp_t    timer_rsp;

  mem_fabric mem_fabric_i (
    .clk_pll    (clk_pll),
    .rst_n      (rst_n),
    .bus_req    (bus_req),
    .bus_rsp    (bus_rsp),
    .bram_req   (bram_req),
    .bram_rdata (bram_rdata),
    .uart_req   (uart_req),
    .timer_req  (timer_req),
    .uart_rsp   (uart_rsp),
    .timer_rsp  (timer_rsp)
  );

  bram bram_i (
    .clk_pll (clk_pll),
    .req     (bram_req),
    .rdata   (bram_rdata)
  );

  uart_periph uart_i (
    .clk_pll (clk_pll),
    .rst_n   (rst_n),
    .req     (uart_req),
    .rsp     (uart_rsp),
    .rx      (rx),
    .tx      (tx)
  );

  timer_periph timer_i (
    .clk_pll   (clk_pll),
    .rst_n     (rst_n),
    .rtc       (rtc),
    .req       (timer_req),
    .rsp       (timer_rsp),
    .timer_irq (timer_irq)
  );

endmodule

`default_nettype wire

//--- rtl/timer_periph.sv
`timescale 1ns/1ps
`default_nettype none

module timer_periph (
  input  logic              clk_pll,
  input  logic              rst_n,
  input  logic              rtc,
  input  soc_pkg::mem_req_t req,
  output soc_pkg::mem_rsp_t rsp,
  output logic              timer_irq
);
  import soc_pkg::*;

  logic        rsp_ready;
  logic [31:0] rsp_rdata;
  logic        accept;
  logic        wr;
  logic        rtc_meta;
  logic        rtc_sync;
  logic        rtc_prev;
  logic        rtc_tick;
  logic [63:0] mtime;
  logic [63:0] mtimecmp;

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  strb);
    logic [31:0] result;
    result = old_word;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        result[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return result;
  endfunction

  assign accept    = req.valid & ~rsp_ready;
  assign wr        = accept & (|req.wstrb);
  assign rtc_tick  = rtc_sync & ~rtc_prev;                    // rising edge of rtc.
  assign timer_irq = (mtime >= mtimecmp);
  assign rsp       = {rsp_ready, rsp_rdata};

  // ==========================================================================
  // counter and compare
  // ==========================================================================

  always_ff @(posedge clk_pll or negedge rst_n) begin
    if (!rst_n) begin
      rtc_meta  <= 1'b0;
      rtc_sync  <= 1'b0;
      rtc_prev  <= 1'b0;
      rsp_ready <= 1'b0;
      mtime     <= '0;
      mtimecmp  <= '1;                                        // no interrupt out of reset.
    end else begin
      rtc_meta  <= rtc;
      rtc_sync  <= rtc_meta;
      rtc_prev  <= rtc_sync;
      rsp_ready <= accept;
      if (wr && req.addr[3:0] == TIMER_REG_TIME_LO) begin
        mtime[31:0] <= merge_bytes(mtime[31:0], req.wdata, req.wstrb);
      end else if (wr && req.addr[3:0] == TIMER_REG_TIME_HI) begin
        mtime[63:32] <= merge_bytes(mtime[63:32], req.wdata, req.wstrb);
      end else if (rtc_tick) begin
        mtime <= mtime + 64'd1;
      end
      if (wr && req.addr[3:0] == TIMER_REG_CMP_LO) begin
        mtimecmp[31:0] <= merge_bytes(mtimecmp[31:0], req.wdata, req.wstrb);
      end else if (wr && req.addr[3:0] == TIMER_REG_CMP_HI) begin
        mtimecmp[63:32] <= merge_bytes(mtimecmp[63:32], req.wdata, req.wstrb);
      end
    end
  end

  always_ff @(posedge clk_pll) begin
    if (accept) begin
      case (req.addr[3:0])
        TIMER_REG_TIME_LO: rsp_rdata <= mtime[31:0];
        TIMER_REG_TIME_HI: rsp_rdata <= mtime[63:32];
        TIMER_REG_CMP_LO:  rsp_rdata <= mtimecmp[31:0];
        TIMER_REG_CMP_HI:  rsp_rdata <= mtimecmp[63:32];
        default:           rsp_rdata <= '0;
      endcase
    end
  end

  a_irq_after_reset: assert property (@(posedge clk_pll)
    $rose(rst_n) |-> !timer_irq)
    else $error("timer_periph: interrupt raised right after reset");

endmodule

`default_nettype wire

//--- rtl/uart_periph.sv
`timescale 1ns/1ps
`default_nettype none

module uart_periph (
  input  logic              clk_pll,
  input  logic              rst_n,
  input  soc_pkg::mem_req_t req,
  output soc_pkg::mem_rsp_t rsp,
  input  logic              rx,
  output logic              tx
);
  import soc_pkg::*;

  logic                     rsp_ready;
  logic [31:0]              rsp_rdata;
  logic                     accept;
  logic                     wr;
  logic                     rd;
  logic                     data_sel;
  logic                     status_sel;
  logic                     tx_load;
  logic                     tx_busy;
  logic                     tx_q;
  logic                     tx_bit_end;
  logic [UART_FRAME_BITS-1:0] tx_shift;
  logic [UART_CNT_BITS-1:0] tx_clk_cnt;
  logic [3:0]               tx_bit_cnt;
  logic                     rx_meta;
  logic                     rx_sync;
  logic                     rx_prev;
  logic                     rx_busy;
  logic                     rx_sample;
  logic                     rx_stop_ok;
  logic [UART_CNT_BITS-1:0] rx_clk_cnt;
  logic [3:0]               rx_bit_cnt;
  logic [7:0]               rx_shift;
  logic [7:0]               rx_data;
  logic                     rx_valid;

  assign accept     = req.valid & ~rsp_ready;
  assign wr         = accept & (|req.wstrb);
  assign rd         = accept & ~(|req.wstrb);
  assign data_sel   = (req.addr[3:0] == UART_REG_DATA);
  assign status_sel = (req.addr[3:0] == UART_REG_STATUS);
  assign tx_load    = wr & data_sel & req.wstrb[0] & ~tx_busy;  // dropped while busy.
  assign tx_bit_end = tx_clk_cnt == UART_CNT_BITS'(UART_CLKS_PER_BIT - 1);
  assign rx_sample  = rx_busy & (rx_clk_cnt == '0);
  assign rx_stop_ok = rx_sample & (rx_bit_cnt == 4'(UART_FRAME_BITS - 1)) & rx_sync;
  assign rsp        = {rsp_ready, rsp_rdata};
  assign tx         = tx_q;

  // ==========================================================================
  // register access
  // ==========================================================================

  always_ff @(posedge clk_pll or negedge rst_n) begin
    if (!rst_n) begin
      rsp_ready <= 1'b0;
    end else begin
      rsp_ready <= accept;
    end
  end

  always_ff @(posedge clk_pll) begin
    if (accept) begin
      if (rd && data_sel) begin
        rsp_rdata <= {24'b0, rx_data};
      end else if (rd && status_sel) begin
        rsp_rdata <= {30'b0, rx_valid, tx_busy};
      end else begin
        rsp_rdata <= '0;
      end
    end
  end

  // ==========================================================================
  // transmitter
  // ==========================================================================

  always_ff @(posedge clk_pll or negedge rst_n) begin
    if (!rst_n) begin
      tx_busy    <= 1'b0;
      tx_clk_cnt <= '0;
      tx_bit_cnt <= '0;
      tx_q       <= 1'b1;
    end else begin
      tx_q <= tx_busy ? tx_shift[0] : 1'b1;                   // line idles high.
      if (tx_load) begin
        tx_busy    <= 1'b1;
        tx_clk_cnt <= '0;
        tx_bit_cnt <= '0;
      end else if (tx_busy) begin
        if (tx_bit_end) begin
          tx_clk_cnt <= '0;
          tx_bit_cnt <= tx_bit_cnt + 1'b1;
          if (tx_bit_cnt == 4'(UART_FRAME_BITS - 1)) begin
            tx_busy <= 1'b0;
          end
        end else begin
          tx_clk_cnt <= tx_clk_cnt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_pll) begin
    if (tx_load) begin
      tx_shift <= {1'b1, req.wdata[7:0], 1'b0};
    end else if (tx_busy && tx_bit_end) begin
      tx_shift <= {1'b1, tx_shift[UART_FRAME_BITS-1:1]};  // lsb first.
    end
  end

  // ==========================================================================
  // receiver
  // ==========================================================================

  always_ff @(posedge clk_pll or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta    <= 1'b1;
      rx_sync    <= 1'b1;
      rx_prev    <= 1'b1;
      rx_busy    <= 1'b0;
      rx_clk_cnt <= '0;
      rx_bit_cnt <= '0;
      rx_valid   <= 1'b0;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
      if (rd && data_sel) begin
        rx_valid <= 1'b0;
      end
      if (rx_stop_ok) begin
        rx_valid <= 1'b1;                                     // new byte wins over clear.
      end
      if (!rx_busy) begin
        if (rx_prev && !rx_sync) begin
          rx_busy    <= 1'b1;
          rx_clk_cnt <= UART_CNT_BITS'(UART_CLKS_PER_BIT / 2 - 1);  // aim at mid-bit.
          rx_bit_cnt <= '0;
        end
      end else if (rx_sample) begin
        rx_clk_cnt <= UART_CNT_BITS'(UART_CLKS_PER_BIT - 1);
        rx_bit_cnt <= rx_bit_cnt + 1'b1;
        if ((rx_bit_cnt == '0 && rx_sync) || rx_bit_cnt == 4'(UART_FRAME_BITS - 1)) begin
          rx_busy <= 1'b0;                                    // glitch or frame done.
        end
      end else begin
        rx_clk_cnt <= rx_clk_cnt - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_pll) begin
    if (rx_sample && rx_bit_cnt != '0 && rx_bit_cnt < 4'(UART_FRAME_BITS - 1)) begin
      rx_shift <= {rx_sync, rx_shift[7:1]};
    end
    if (rx_stop_ok) begin
      rx_data <= rx_shift;
    end
  end

  // stop bit has to leave the line high when the shifter goes idle.
  a_tx_idle_high: assert property (@(posedge clk_pll) disable iff (!rst_n)
    !tx_busy |-> tx)
    else $error("uart_periph: tx low while transmitter idle");

endmodule

`default_nettype wire

//--- src.f
rtl/soc_pkg.sv
rtl/mem_fabric.sv
rtl/bram.sv
rtl/uart_periph.sv
rtl/timer_periph.sv
rtl/soc_top.sv
verification/tb_soc.sv

//--- verification/tb_soc.sv
`timescale 1ns/1ps
`default_nettype none

module tb_soc;
  import soc_pkg::*;

  localparam logic [31:0] RAM_BASE = 32'h0000_0400;
  localparam int READY_WAIT  = 16;
  localparam int ACCESS_CLKS = 4;                             // idle, request, ready, release.
  localparam int FRAME_CLKS  = UART_FRAME_BITS * UART_CLKS_PER_BIT;
  localparam int RTC_HALF    = 20;
  localparam int RTC_EDGES   = 8;
  // about 100 bus accesses, six frames of time and the rtc run, with margin.
  localparam int EXPECTED_CLKS = 100 * ACCESS_CLKS + 6 * FRAME_CLKS + RTC_EDGES * 2 * RTC_HALF;
  localparam int CYCLE_LIMIT   = 5 * EXPECTED_CLKS;

  logic     clk_pll;
  logic     rst_n;
  logic     rtc;
  mem_req_t bus_req;
  mem_rsp_t bus_rsp;
  logic     tx;
  logic     timer_irq;
  wire      serial_loop;
  int       error_count;
  int       cycle_count;
  integer   seed;

  assign serial_loop = tx;                                    // uart loopback.

  soc_top soc_top_i (
    .clk_pll   (clk_pll),
    .rst_n     (rst_n),
    .rtc       (rtc),
    .bus_req   (bus_req),
    .bus_rsp   (bus_rsp),
    .rx        (serial_loop),
    .tx        (tx),
    .timer_irq (timer_irq)
  );

  always #5 clk_pll = ~clk_pll;

  // ==========================================================================
  // checks and bus access
  // ==========================================================================

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_that(input logic cond, input string what);
    assert (cond) else begin
      $display("%s (at %0t ns)", what, $time);
      error_count++;
    end
  endtask

  function automatic logic [31:0] apply_strobes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  strb);
    logic [31:0] mask;
    mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old_word & ~mask) | (new_word & mask);
  endfunction

  task automatic bus_transfer(input logic [31:0] addr, input logic [31:0] wdata,
                              input logic [3:0] wstrb, output logic [31:0] rdata);
    int   waited;
    logic got_ready;
    waited    = 0;
    got_ready = 1'b0;
    rdata     = '0;
    @(negedge clk_pll);
    bus_req.valid = 1'b1;
    bus_req.instr = 1'b0;
    bus_req.addr  = addr;
    bus_req.wdata = wdata;
    bus_req.wstrb = wstrb;
    while (!got_ready && waited < READY_WAIT) begin
      @(negedge clk_pll);
      waited++;
      if (bus_rsp.ready) begin
        got_ready = 1'b1;
        rdata     = bus_rsp.rdata;
      end
    end
    @(negedge clk_pll);                                       // ready sampled at the edge before.
    bus_req = '0;
    check_that(got_ready, $sformatf("bus request to address %h got no ready", addr));
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    logic [31:0] unused;
    bus_transfer(addr, data, strb, unused);
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
    bus_transfer(addr, 32'd0, 4'b0000, data);
  endtask

  task automatic receive_tx_frame(output logic [7:0] data, output logic ok);
    int   waited;
    logic found;
    waited = 0;
    found  = 1'b0;
    data   = '0;
    ok     = 1'b0;
    while (!found && waited < 4 * READY_WAIT) begin
      @(negedge clk_pll);
      waited++;
      found = (tx == 1'b0);
    end
    if (found) begin
      repeat (UART_CLKS_PER_BIT / 2) @(negedge clk_pll);
      ok = (tx == 1'b0);                                      // middle of the start bit.
      for (int b = 0; b < 8; b++) begin
        repeat (UART_CLKS_PER_BIT) @(negedge clk_pll);
        data[b] = tx;
      end
      repeat (UART_CLKS_PER_BIT) @(negedge clk_pll);
      ok = ok & tx;                                           // stop bit.
    end
  endtask

  task automatic wait_rx_valid(output logic [31:0] status);
    int tries;
    tries = 0;
    bus_read(UART_BASE_ADDR + UART_REG_STATUS, status);
    while (!status[1] && tries < FRAME_CLKS) begin
      bus_read(UART_BASE_ADDR + UART_REG_STATUS, status);
      tries++;
    end
  endtask

  // ==========================================================================
  // directed tests
  // ==========================================================================

  task automatic test_reset();
    logic [31:0] status;
    check_value("tx", 32'(tx), 32'd1);
    check_value("timer_irq", 32'(timer_irq), 32'd0);
    bus_read(UART_BASE_ADDR + UART_REG_STATUS, status);
    check_value("uart status", status, 32'd0);
  endtask

  task automatic test_ram();
    logic [31:0] model [16];
    logic [31:0] data;
    logic [31:0] got;
    for (int i = 0; i < 16; i++) begin
      model[i] = $random(seed);
      bus_write(RAM_BASE + 32'(4 * i), model[i], 4'hf);
    end
    for (int i = 0; i < 16; i++) begin
      bus_read(RAM_BASE + 32'(4 * i), got);
      check_value("ram rdata", got, model[i]);
    end
    for (int i = 0; i < 16; i++) begin
      data     = $random(seed);
      model[i] = apply_strobes(model[i], data, 4'(i));        // strobe 0 is a plain read.
      bus_write(RAM_BASE + 32'(4 * i), data, 4'(i));
    end
    for (int i = 0; i < 16; i++) begin
      bus_read(RAM_BASE + 32'(4 * i), got);
      check_value("ram rdata after strobes", got, model[i]);
      bus_read(RAM_BASE + 32'h1000 + 32'(4 * i), got);
      check_value("ram rdata 4 KB alias", got, model[i]);
    end
  endtask

  task automatic test_uart_tx();
    logic [31:0] status;
    logic [7:0]  frame_byte;
    logic        frame_ok;
    fork
      begin
        bus_write(UART_BASE_ADDR + UART_REG_DATA, 32'h0000_00a5, 4'b0001);
        bus_read(UART_BASE_ADDR + UART_REG_STATUS, status);
        check_value("uart status tx_busy", 32'(status[0]), 32'd1);
      end
      receive_tx_frame(frame_byte, frame_ok);
    join
    check_that(frame_ok, "no valid 8N1 frame appeared on tx");
    check_value("tx frame byte", 32'(frame_byte), 32'h0000_00a5);
  endtask

  task automatic test_uart_loopback();
    logic [31:0] status;
    logic [31:0] data;
    wait_rx_valid(status);
    check_value("uart status rx_valid", 32'(status[1]), 32'd1);
    bus_read(UART_BASE_ADDR + UART_REG_DATA, data);
    check_value("uart rx data", data, 32'h0000_00a5);
    bus_read(UART_BASE_ADDR + UART_REG_STATUS, status);
    check_value("uart status rx_valid", 32'(status[1]), 32'd0);
    bus_write(UART_BASE_ADDR + UART_REG_DATA, 32'h0000_003c, 4'b0001);
    bus_write(UART_BASE_ADDR + UART_REG_DATA, 32'h0000_00c3, 4'b0001);  // lands while busy.
    wait_rx_valid(status);
    check_value("uart status rx_valid", 32'(status[1]), 32'd1);
    bus_read(UART_BASE_ADDR + UART_REG_DATA, data);
    check_value("uart rx data", data, 32'h0000_003c);
    repeat (2 * FRAME_CLKS) @(negedge clk_pll);
    bus_read(UART_BASE_ADDR + UART_REG_STATUS, status);
    check_value("uart status after dropped write", status, 32'd0);
  endtask

  task automatic test_timer();
    logic [31:0] mtime_lo;
    bus_write(TIMER_BASE_ADDR + TIMER_REG_TIME_HI, 32'd0, 4'hf);
    bus_write(TIMER_BASE_ADDR + TIMER_REG_TIME_LO, 32'd0, 4'hf);
    bus_write(TIMER_BASE_ADDR + TIMER_REG_CMP_LO, 32'd5, 4'hf);
    bus_write(TIMER_BASE_ADDR + TIMER_REG_CMP_HI, 32'd0, 4'hf);
    check_value("timer_irq", 32'(timer_irq), 32'd0);
    for (int e = 1; e <= RTC_EDGES; e++) begin
      @(negedge clk_pll);
      rtc = 1'b1;
      repeat (RTC_HALF) @(negedge clk_pll);
      rtc = 1'b0;
      bus_read(TIMER_BASE_ADDR + TIMER_REG_TIME_LO, mtime_lo);
      check_value("mtime", mtime_lo, 32'(e));                // one tick per rtc edge.
      check_value("timer_irq", 32'(timer_irq), 32'(e >= 5));
      repeat (RTC_HALF - ACCESS_CLKS) @(negedge clk_pll);
    end
    bus_write(TIMER_BASE_ADDR + TIMER_REG_CMP_HI, 32'd1, 4'hf);
    check_value("timer_irq after compare raised", 32'(timer_irq), 32'd0);
  endtask

  initial begin
    seed        = 88172;
    error_count = 0;
    clk_pll     = 1'b0;
    rst_n       = 1'b0;
    rtc         = 1'b0;
    bus_req     = '0;
    repeat (3) @(negedge clk_pll);
    rst_n = 1'b1;
    test_reset();
    test_ram();
    test_uart_tx();
    test_uart_loopback();
    test_timer();
    $display("summary: %0d errors", error_count);
    if (error_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < CYCLE_LIMIT) begin
      @(posedge clk_pll);
      cycle_count++;
    end
    $display("timeout: run stopped after %0d cycles, %0d errors", cycle_count, error_count);
    $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire
